//--- common/ddr_stripe_pkg.sv
package ddr_stripe_pkg;

    // =========================================================================
    // Stream payload
    // =========================================================================

    localparam int AXI_DATA_BITS = 64;
    localparam int AXI_KEEP_BITS = AXI_DATA_BITS / 8;

    // One beat of every stream in the design, 73 bits.
    typedef struct packed {
        logic [AXI_DATA_BITS-1:0] tdata;
        logic [AXI_KEEP_BITS-1:0] tkeep;
        logic                     tlast;
    } axis_beat_t;

    // =========================================================================
    // Register port
    // =========================================================================

    localparam int REG_DATA_BITS = 32;

    typedef enum logic [1:0] {
        REG_ACTIVE     = 2'd0,
        REG_SINK_BEATS = 2'd1,
        REG_SRC_BEATS  = 2'd2
    } reg_addr_t;

    // Single-cycle strobes, no back-pressure.
    typedef struct packed {
        logic                     wr;
        logic                     rd;
        reg_addr_t                addr;
        logic [REG_DATA_BITS-1:0] wdata;
    } reg_req_t;

endpackage

//--- ddr_stripe/gather_mux.sv
`timescale 1ns/1ps

module gather_mux import ddr_stripe_pkg::*; #(
    parameter int  N_CHAN = 4,
    localparam int PTR_W  = $clog2(N_CHAN),
    localparam int CNT_W  = $clog2(N_CHAN + 1)
) (
    input  logic                   aclk,
    input  logic                   aresetn,

    // Source FIFO read ports.
    input  axis_beat_t [N_CHAN-1:0] chan_beat,
    input  logic [N_CHAN-1:0]      chan_valid,
    output logic [N_CHAN-1:0]      chan_ready,

    // Host side.
    output axis_beat_t             host_beat,
    output logic                   host_valid,
    input  logic                   host_ready,

    input  logic [CNT_W-1:0]       n_active,
    input  logic                   cfg_restart,
    output logic                   src_fire
);

    logic [PTR_W-1:0] sel_q;
    logic [CNT_W-1:0] sel_inc;

    // Only the channel under the pointer may deliver, which keeps host order.
    assign host_beat  = chan_beat[sel_q];
    assign host_valid = chan_valid[sel_q];
    assign src_fire   = host_valid && host_ready;

    always_comb begin
        chan_ready = '0;
        chan_ready[sel_q] = host_ready;
    end

    // Same wrap rule as the striping side.
    assign sel_inc = CNT_W'(sel_q) + 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sel_q <= '0;
        end else if (cfg_restart) begin
            sel_q <= '0;
        end else if (src_fire) begin
            if (sel_inc >= n_active) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_inc[PTR_W-1:0];
            end
        end
    end

    a_sel_in_range: assert property (@(posedge aclk) disable iff (!aresetn || cfg_restart)
        CNT_W'(sel_q) < n_active)
        else $error("gather_mux pointer %0d not below n_active %0d", sel_q, n_active);

endmodule

//--- ddr_stripe/stripe_mux.sv
`timescale 1ns/1ps

module stripe_mux import ddr_stripe_pkg::*; #(
    parameter int  N_CHAN = 4,
    localparam int PTR_W  = $clog2(N_CHAN),
    localparam int CNT_W  = $clog2(N_CHAN + 1)
) (
    input  logic              aclk,
    input  logic              aresetn,

    // Host side.
    input  axis_beat_t        host_beat,
    input  logic              host_valid,
    output logic              host_ready,

    // Channel FIFO write ports.
    output axis_beat_t        chan_beat,
    output logic [N_CHAN-1:0] chan_valid,
    input  logic [N_CHAN-1:0] chan_ready,

    // Control from the register block.
    input  logic [CNT_W-1:0]  n_active,
    input  logic              cfg_restart,
    output logic              sink_fire
);

    logic [PTR_W-1:0] sel_q;
    logic [CNT_W-1:0] sel_inc;

    // =========================================================================
    // Distribution
    // =========================================================================

    // The beat goes to every channel, but only the selected one sees valid.
    assign chan_beat = host_beat;

    always_comb begin
        chan_valid = '0;
        chan_valid[sel_q] = host_valid;
    end

    assign host_ready = chan_ready[sel_q];
    assign sink_fire  = host_valid && host_ready;

    // =========================================================================
    // Round-robin pointer
    // =========================================================================

    assign sel_inc = CNT_W'(sel_q) + 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sel_q <= '0;
        end else if (cfg_restart) begin
            sel_q <= '0;
        end else if (sink_fire) begin
            // Wrap at the active count, not at N_CHAN.
            if (sel_inc >= n_active) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_inc[PTR_W-1:0];
            end
        end
    end

    // n_active may drop under the pointer during the restart cycle.
    a_sel_in_range: assert property (@(posedge aclk) disable iff (!aresetn || cfg_restart)
        CNT_W'(sel_q) < n_active)
        else $error("stripe_mux pointer %0d not below n_active %0d", sel_q, n_active);

endmodule

//--- flist.f
common/ddr_stripe_pkg.sv
hw/axis_chan_fifo.sv
ddr_stripe/stripe_mux.sv
ddr_stripe/gather_mux.sv
hw/stripe_regs.sv
hw/ddr_stripe_top.sv
verification/tb_ddr_stripe.sv

//--- hw/axis_chan_fifo.sv
`timescale 1ns/1ps

module axis_chan_fifo import ddr_stripe_pkg::*; #(
    parameter int  FIFO_DEPTH = 8,
    localparam int PTR_W      = $clog2(FIFO_DEPTH),
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
    input  logic       aclk,
    input  logic       aresetn,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    axis_beat_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    // A full FIFO still takes a beat when one leaves in the same cycle.
    assign in_ready = (count != CNT_W'(FIFO_DEPTH)) || out_ready;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        count <= CNT_W'(FIFO_DEPTH))
        else $error("axis_chan_fifo occupancy %0d above depth", count);

endmodule

//--- hw/ddr_stripe_top.sv
`timescale 1ns/1ps

module ddr_stripe_top import ddr_stripe_pkg::*; #(
    parameter int  N_CHAN     = 4,
    parameter int  FIFO_DEPTH = 8,
    localparam int CNT_W      = $clog2(N_CHAN + 1)
) (
    input  logic                     aclk,
    input  logic                     aresetn,

    // Host streams.
    input  axis_beat_t               host_in_beat,
    input  logic                     host_in_valid,
    output logic                     host_in_ready,
    output axis_beat_t               host_out_beat,
    output logic                     host_out_valid,
    input  logic                     host_out_ready,

    // Card streams, one per DDR channel.
    output axis_beat_t [N_CHAN-1:0]  card_out_beat,
    output logic [N_CHAN-1:0]        card_out_valid,
    input  logic [N_CHAN-1:0]        card_out_ready,
    input  axis_beat_t [N_CHAN-1:0]  card_in_beat,
    input  logic [N_CHAN-1:0]        card_in_valid,
    output logic [N_CHAN-1:0]        card_in_ready,

    // Register port.
    input  reg_req_t                 req,
    output logic [REG_DATA_BITS-1:0] rd_data,
    output logic                     rd_valid
);

    axis_beat_t              sink_beat;
    logic [N_CHAN-1:0]       sink_valid;
    logic [N_CHAN-1:0]       sink_ready;
    axis_beat_t [N_CHAN-1:0] src_beat;
    logic [N_CHAN-1:0]       src_valid;
    logic [N_CHAN-1:0]       src_ready;
    logic [CNT_W-1:0]        n_active;
    logic                    cfg_restart;
    logic                    sink_fire;
    logic                    src_fire;

    stripe_mux #(.N_CHAN(N_CHAN)) i_stripe_mux (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .host_beat   (host_in_beat),
        .host_valid  (host_in_valid),
        .host_ready  (host_in_ready),
        .chan_beat   (sink_beat),
        .chan_valid  (sink_valid),
        .chan_ready  (sink_ready),
        .n_active    (n_active),
        .cfg_restart (cfg_restart),
        .sink_fire   (sink_fire)
    );

    // =========================================================================
    // Per-channel FIFOs
    // =========================================================================

    for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
        axis_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_sink_fifo (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_beat   (sink_beat),
            .in_valid  (sink_valid[i]),
            .in_ready  (sink_ready[i]),
            .out_beat  (card_out_beat[i]),
            .out_valid (card_out_valid[i]),
            .out_ready (card_out_ready[i])
        );

        axis_chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_src_fifo (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_beat   (card_in_beat[i]),
            .in_valid  (card_in_valid[i]),
            .in_ready  (card_in_ready[i]),
            .out_beat  (src_beat[i]),
            .out_valid (src_valid[i]),
            .out_ready (src_ready[i])
        );
    end

    gather_mux #(.N_CHAN(N_CHAN)) i_gather_mux (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .chan_beat   (src_beat),
        .chan_valid  (src_valid),
        .chan_ready  (src_ready),
        .host_beat   (host_out_beat),
        .host_valid  (host_out_valid),
        .host_ready  (host_out_ready),
        .n_active    (n_active),
        .cfg_restart (cfg_restart),
        .src_fire    (src_fire)
    );

    stripe_regs #(.N_CHAN(N_CHAN)) i_stripe_regs (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req         (req),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .n_active    (n_active),
        .cfg_restart (cfg_restart),
        .sink_fire   (sink_fire),
        .src_fire    (src_fire)
    );

endmodule

//--- hw/stripe_regs.sv
`timescale 1ns/1ps

module stripe_regs import ddr_stripe_pkg::*; #(
    parameter int  N_CHAN = 4,
    localparam int CNT_W  = $clog2(N_CHAN + 1)
) (
    input  logic                     aclk,
    input  logic                     aresetn,

    input  reg_req_t                 req,
    output logic [REG_DATA_BITS-1:0] rd_data,
    output logic                     rd_valid,

    output logic [CNT_W-1:0]         n_active,
    output logic                     cfg_restart,
    input  logic                     sink_fire,
    input  logic                     src_fire
);

    logic [REG_DATA_BITS-1:0] sink_beats;
    logic [REG_DATA_BITS-1:0] src_beats;
    logic [CNT_W-1:0]         wr_active;
    logic                     wr_act;

    // Writes to the counter addresses fall through here and are dropped.
    assign wr_act = req.wr && (req.addr == REG_ACTIVE);

    // Clamp to 1..N_CHAN.
    always_comb begin
        if (req.wdata == '0) begin
            wr_active = CNT_W'(1);
        end else if (req.wdata > REG_DATA_BITS'(N_CHAN)) begin
            wr_active = CNT_W'(N_CHAN);
        end else begin
            wr_active = req.wdata[CNT_W-1:0];
        end
    end

    // =========================================================================
    // Control state and counters
    // =========================================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            n_active    <= CNT_W'(N_CHAN);
            cfg_restart <= 1'b0;
            sink_beats  <= '0;
            src_beats   <= '0;
            rd_valid    <= 1'b0;
        end else begin
            cfg_restart <= wr_act;
            rd_valid    <= req.rd;
            if (wr_act) begin
                n_active <= wr_active;
            end
            // Restart lands with the new n_active, one cycle after the write.
            if (cfg_restart) begin
                sink_beats <= '0;
                src_beats  <= '0;
            end else begin
                sink_beats <= sink_beats + REG_DATA_BITS'(sink_fire);
                src_beats  <= src_beats + REG_DATA_BITS'(src_fire);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req.rd) begin
            case (req.addr)
                REG_ACTIVE:     rd_data <= REG_DATA_BITS'(n_active);
                REG_SINK_BEATS: rd_data <= sink_beats;
                REG_SRC_BEATS:  rd_data <= src_beats;
                default:        rd_data <= '0;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ddr_stripe -o sim_ddr_stripe
./obj_dir/sim_ddr_stripe | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- verification/tb_ddr_stripe.sv
`timescale 1ns/1ps

module tb_ddr_stripe import ddr_stripe_pkg::*;;

    localparam int N_CHAN          = 4;
    localparam int FIFO_DEPTH      = 8;
    localparam int TOTAL_BEATS     = 16 + 16 + 9 + (4 * FIFO_DEPTH + 1) + 32;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 12 + 300;

    logic                     aclk;
    logic                     aresetn;
    axis_beat_t               host_in_beat;
    logic                     host_in_valid;
    logic                     host_in_ready;
    axis_beat_t               host_out_beat;
    logic                     host_out_valid;
    logic                     host_out_ready;
    axis_beat_t [N_CHAN-1:0]  card_out_beat;
    logic [N_CHAN-1:0]        card_out_valid;
    logic [N_CHAN-1:0]        card_out_ready;
    axis_beat_t [N_CHAN-1:0]  card_in_beat;
    logic [N_CHAN-1:0]        card_in_valid;
    logic [N_CHAN-1:0]        card_in_ready;
    reg_req_t                 req;
    logic [REG_DATA_BITS-1:0] rd_data;
    logic                     rd_valid;

    // Reference model state.
    axis_beat_t  sent_q[$];
    int          sent_chan_q[$];
    bit          taken[$];
    axis_beat_t  ret_q[$];
    axis_beat_t  loop_q[N_CHAN][$];
    int          model_n = N_CHAN;
    int          model_ptr = 0;
    int          sink_cnt = 0;
    int          src_cnt = 0;
    int          err_cnt = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    logic        stall_en = 1'b0;
    logic [15:0] lfsr_state = 16'd71;

    ddr_stripe_top #(.N_CHAN(N_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_bit();
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        return lfsr_state[0];
    endfunction

    function automatic axis_beat_t next_beat();
        axis_beat_t b;
        for (int i = 0; i < $bits(axis_beat_t); i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    // =========================================================================
    // Compare tasks
    // =========================================================================

    task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_chan(input string name, input int got, input int exp);
        if (got != exp) begin
            err_cnt++;
            $display("Fail %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic match_card_out(input int ch, input axis_beat_t b);
        int k;
        k = -1;
        foreach (sent_q[j]) begin
            if (k < 0 && !taken[j] && sent_q[j].tdata == b.tdata) begin
                k = j;
            end
        end
        if (k < 0) begin
            err_cnt++;
            $display("Beat on card_out[%0d] matches no beat sent by the host", ch);
        end else begin
            taken[k] = 1'b1;
            check_chan("card_out channel", ch, sent_chan_q[k]);
            check_beat("card_out_beat", b, sent_q[k]);
        end
    endtask

    // =========================================================================
    // Monitors and card-side loopback
    // =========================================================================

    always @(posedge aclk) begin
        if (aresetn) begin
            if (host_in_valid && host_in_ready) begin
                sent_q.push_back(host_in_beat);
                sent_chan_q.push_back(model_ptr);
                taken.push_back(1'b0);
                ret_q.push_back(host_in_beat);
                model_ptr = (model_ptr + 1) % model_n;
                sink_cnt++;
            end
            for (int i = 0; i < N_CHAN; i++) begin
                if (card_out_valid[i] && card_out_ready[i]) begin
                    match_card_out(i, card_out_beat[i]);
                end
            end
            if (host_out_valid && host_out_ready) begin
                src_cnt++;
                if (ret_q.size() == 0) begin
                    err_cnt++;
                    $display("Beat returned to the host that was never sent");
                end else begin
                    check_beat("host_out_beat", host_out_beat, ret_q.pop_front());
                end
            end
        end
    end

    // Card holds its side whenever card_out_ready is low.
    always @(posedge aclk) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (card_in_valid[i] && card_in_ready[i]) begin
                void'(loop_q[i].pop_front());
            end
            if (card_out_valid[i] && card_out_ready[i]) begin
                loop_q[i].push_back(card_out_beat[i]);
            end
            card_in_valid[i] <= (loop_q[i].size() != 0);
            if (loop_q[i].size() != 0) begin
                card_in_beat[i] <= loop_q[i][0];
            end
        end
    end

    always @(posedge aclk) begin
        host_out_ready <= stall_en ? lfsr_bit() : 1'b1;
    end

    // =========================================================================
    // Driver tasks
    // =========================================================================

    task automatic send_beats(input int n);
        @(posedge aclk);
        for (int k = 0; k < n; k++) begin
            host_in_beat  <= next_beat();
            host_in_valid <= 1'b1;
            @(posedge aclk);
            while (!host_in_ready) @(posedge aclk);
        end
        host_in_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge aclk);
        while (ret_q.size() != 0) @(posedge aclk);
        repeat (4) @(posedge aclk);
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        reg_req_t r;
        r       = '0;
        r.wr    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        @(posedge aclk);
        req <= r;
        @(posedge aclk);
        req <= '0;
        if (addr == REG_ACTIVE) begin
            model_n   = (data == 0) ? 1 : ((data > N_CHAN) ? N_CHAN : int'(data));
            model_ptr = 0;
            sink_cnt  = 0;
            src_cnt   = 0;
        end
        repeat (2) @(posedge aclk);
    endtask

    task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
        reg_req_t r;
        logic     early;
        r      = '0;
        r.rd   = 1'b1;
        r.addr = addr;
        @(posedge aclk);
        req <= r;
        @(posedge aclk);
        req <= '0;
        early = rd_valid;
        @(posedge aclk);
        if (early || !rd_valid) begin
            err_cnt++;
            $display("rd_valid was not high exactly one cycle after the rd strobe");
        end
        data = rd_data;
    endtask

    task automatic report(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("%s: pass", name);
        end else begin
            fail_cnt++;
            $display("%s: FAIL with %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    // =========================================================================
    // Directed tests
    // =========================================================================

    task automatic test_striping();
        int          e0;
        logic [31:0] v;
        e0 = err_cnt;
        reg_read(REG_ACTIVE, v);
        check_reg("rd_data", v, 32'(N_CHAN));
        send_beats(16);
        wait_idle();
        report("striping order", e0);
    endtask

    task automatic test_gather();
        int          e0;
        logic [31:0] v;
        e0 = err_cnt;
        send_beats(16);
        wait_idle();
        // Every beat the host sent since the last restart has come back.
        reg_read(REG_SRC_BEATS, v);
        check_reg("rd_data", v, 32'(sink_cnt));
        report("gather order", e0);
    endtask

    task automatic test_active();
        int          e0;
        logic [31:0] v;
        e0 = err_cnt;
        reg_write(REG_ACTIVE, 32'd3);
        send_beats(9);
        wait_idle();
        reg_write(REG_ACTIVE, 32'd0);
        reg_read(REG_ACTIVE, v);
        check_reg("rd_data", v, 32'd1);
        reg_write(REG_ACTIVE, 32'd9);
        reg_read(REG_ACTIVE, v);
        check_reg("rd_data", v, 32'd4);
        report("active-channel change", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int acc;
        e0  = err_cnt;
        acc = 0;
        @(posedge aclk);
        card_out_ready <= '0;
        host_in_beat   <= next_beat();
        host_in_valid  <= 1'b1;
        @(posedge aclk);
        while (host_in_ready) begin
            acc++;
            host_in_beat <= next_beat();
            @(posedge aclk);
        end
        check_reg("accepted beats", 32'(acc), 32'(4 * FIFO_DEPTH));
        card_out_ready <= '1;
        @(posedge aclk);
        while (!host_in_ready) @(posedge aclk);
        host_in_valid <= 1'b0;
        wait_idle();
        report("back-pressure", e0);
    endtask

    task automatic test_counters();
        int          e0;
        logic [31:0] v;
        e0 = err_cnt;
        reg_read(REG_SINK_BEATS, v);
        check_reg("rd_data", v, 32'(sink_cnt));
        reg_read(REG_SRC_BEATS, v);
        check_reg("rd_data", v, 32'(src_cnt));
        report("beat counters", e0);
    endtask

    task automatic test_host_stall();
        int e0;
        e0 = err_cnt;
        stall_en = 1'b1;
        send_beats(32);
        wait_idle();
        stall_en = 1'b0;
        report("host stall", e0);
    endtask

    initial begin
        aresetn        <= 1'b0;
        host_in_beat   <= '0;
        host_in_valid  <= 1'b0;
        host_out_ready <= 1'b1;
        card_out_ready <= '1;
        card_in_beat   <= '0;
        card_in_valid  <= '0;
        req            <= '0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        test_striping();
        test_gather();
        test_active();
        test_backpressure();
        test_counters();
        test_host_stall();
        $display("Tests run: %0d, failed: %0d, mismatches: %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule
